// ==== include/axi_params.svh ====
`ifndef AXI_PARAMS_SVH
`define AXI_PARAMS_SVH

// AXI bus widths
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4
`define AXI_ADDR_BITS 32
`define AXI_ID_BITS 4
`define AXI_LEN_BITS 4

// Address bits that pick the slave region
`define REGION_MSB 17
`define REGION_LSB 16

`define MEM_WORDS_LOG2 8

`endif

// ==== rtl/axi_pkg.sv ====
`include "axi_params.svh"

package axi_pkg;

  typedef logic [`AXI_DATA_BITS-1:0] axi_data_t;
  typedef logic [`AXI_STRB_BITS-1:0] axi_strb_t;
  typedef logic [`AXI_ADDR_BITS-1:0] axi_addr_t;
  typedef logic [`AXI_ID_BITS-1:0] axi_id_t;
  typedef logic [`AXI_LEN_BITS-1:0] axi_len_t;
  // Only OKAY (2'b00) is ever returned
  typedef logic [1:0] axi_resp_t;
  typedef logic [`MEM_WORDS_LOG2-1:0] mem_index_t;

  // W arbiter state
  typedef enum logic {
    LOCK_M1,
    LOCK_FREE
  } addr_arb_lock_t;

  typedef enum logic [1:0] {
    LOCK_S0,
    LOCK_S1,
    LOCK_S2,
    LOCK_NO
  } data_arb_lock_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_DATA,
    S_RESP
  } slave_state_t;

endpackage

// ==== rtl/aw_router.sv ====
`timescale 1ns/1ps
`include "axi_params.svh"

module aw_router
  import axi_pkg::*;
(
  input  axi_addr_t awaddr_m1,
  input  logic      awvalid_m1,
  output logic      awready_m1,
  output logic      awvalid_s0,
  output logic      awvalid_s1,
  output logic      awvalid_s2,
  input  logic      awready_s0,
  input  logic      awready_s1,
  input  logic      awready_s2
);

  logic [`REGION_MSB-`REGION_LSB:0] region;

  assign region = awaddr_m1[`REGION_MSB:`REGION_LSB];

  // Only the addressed slave sees valid
  assign awvalid_s0 = awvalid_m1 && (region == 2'd0);
  assign awvalid_s1 = awvalid_m1 && (region == 2'd1);
  assign awvalid_s2 = awvalid_m1 && (region == 2'd2);

  // Ready goes back only for a pending request
  always_comb begin
    awready_m1 = 1'b0;
    if (awvalid_m1) begin
      case (region)
        2'd0:    awready_m1 = awready_s0;
        2'd1:    awready_m1 = awready_s1;
        2'd2:    awready_m1 = awready_s2;
        default: awready_m1 = 1'b0;
      endcase
    end
  end

  // Region 3 has no slave behind it, so a request there would hang the master
  always_comb begin
    if (awvalid_m1) begin
      assert #0 (region != 2'd3)
        else $error("aw_router: address 0x%08h decodes to unmapped region 3", awaddr_m1);
    end
  end

endmodule

// ==== rtl/w_router.sv ====
`timescale 1ns/1ps

module w_router
  import axi_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  axi_data_t wdata_m1,
  input  axi_strb_t wstrb_m1,
  input  logic      wlast_m1,
  input  logic      wvalid_m1,
  output logic      wready_m1,
  input  logic      awvalid_m1,
  output axi_data_t wdata_s0,
  output axi_strb_t wstrb_s0,
  output logic      wlast_s0,
  output logic      wvalid_s0,
  input  logic      wready_s0,
  input  logic      awvalid_s0,
  input  logic      awready_s0,
  output axi_data_t wdata_s1,
  output axi_strb_t wstrb_s1,
  output logic      wlast_s1,
  output logic      wvalid_s1,
  input  logic      wready_s1,
  input  logic      awvalid_s1,
  input  logic      awready_s1,
  output axi_data_t wdata_s2,
  output axi_strb_t wstrb_s2,
  output logic      wlast_s2,
  output logic      wvalid_s2,
  input  logic      wready_s2,
  input  logic      awvalid_s2,
  input  logic      awready_s2
);

  addr_arb_lock_t addr_arb_lock;
  addr_arb_lock_t addr_arb_lock_next;
  data_arb_lock_t aw_hs_lock_r;
  data_arb_lock_t aw_slave_lock;
  data_arb_lock_t aw_slave_lock_r;
  data_arb_lock_t w_slave_lock;
  logic           wready_sel;
  logic           fast_transaction;
  logic           slow_transaction;

  // Slave that took the last address; needed when W trails the AW handshake
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      aw_hs_lock_r <= LOCK_NO;
    end else if (awvalid_s0 && awready_s0) begin
      aw_hs_lock_r <= LOCK_S0;
    end else if (awvalid_s1 && awready_s1) begin
      aw_hs_lock_r <= LOCK_S1;
    end else if (awvalid_s2 && awready_s2) begin
      aw_hs_lock_r <= LOCK_S2;
    end
  end

  always_comb begin
    case ({awvalid_s0, awvalid_s1, awvalid_s2})
      3'b100:  aw_slave_lock = LOCK_S0;
      3'b010:  aw_slave_lock = LOCK_S1;
      3'b001:  aw_slave_lock = LOCK_S2;
      default: aw_slave_lock = aw_hs_lock_r;
    endcase
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      addr_arb_lock <= LOCK_FREE;
    end else begin
      addr_arb_lock <= addr_arb_lock_next;
    end
  end

  always_comb begin
    addr_arb_lock_next = LOCK_FREE;
    case (addr_arb_lock)
      LOCK_M1: begin
        addr_arb_lock_next = (wready_sel && wlast_m1) ? LOCK_FREE : LOCK_M1;
      end
      LOCK_FREE: begin
        if (wvalid_m1 && !(wready_sel && wlast_m1)) begin
          addr_arb_lock_next = LOCK_M1;
        end
      end
      default: addr_arb_lock_next = LOCK_FREE;
    endcase
  end

  // Selection is frozen for the rest of the burst
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      aw_slave_lock_r <= LOCK_NO;
    end else if (addr_arb_lock != LOCK_M1 && addr_arb_lock_next == LOCK_M1) begin
      aw_slave_lock_r <= aw_slave_lock;
    end
  end

  assign fast_transaction = wvalid_m1 && awvalid_m1;
  assign slow_transaction = (addr_arb_lock == LOCK_M1);
  assign w_slave_lock = fast_transaction ? aw_slave_lock :
                        slow_transaction ? aw_slave_lock_r : LOCK_NO;
  assign wready_m1 = wready_sel;

  always_comb begin
    wdata_s0   = '0;
    wstrb_s0   = '0;
    wlast_s0   = 1'b0;
    wvalid_s0  = 1'b0;
    wdata_s1   = '0;
    wstrb_s1   = '0;
    wlast_s1   = 1'b0;
    wvalid_s1  = 1'b0;
    wdata_s2   = '0;
    wstrb_s2   = '0;
    wlast_s2   = 1'b0;
    wvalid_s2  = 1'b0;
    wready_sel = 1'b0;
    case (w_slave_lock)
      LOCK_S0: begin
        wdata_s0   = wdata_m1;
        wstrb_s0   = wstrb_m1;
        wlast_s0   = wlast_m1;
        wvalid_s0  = wvalid_m1;
        wready_sel = wready_s0;
      end
      LOCK_S1: begin
        wdata_s1   = wdata_m1;
        wstrb_s1   = wstrb_m1;
        wlast_s1   = wlast_m1;
        wvalid_s1  = wvalid_m1;
        wready_sel = wready_s1;
      end
      LOCK_S2: begin
        wdata_s2   = wdata_m1;
        wstrb_s2   = wstrb_m1;
        wlast_s2   = wlast_m1;
        wvalid_s2  = wvalid_m1;
        wready_sel = wready_s2;
      end
      default: ;
    endcase
  end

  // A beat of a locked burst reaches exactly one slave
  a_w_onehot: assert property (@(posedge clk) disable iff (!rstn)
    (wvalid_m1 && slow_transaction) |-> $onehot({wvalid_s0, wvalid_s1, wvalid_s2}))
    else $error("w_router: W beat of a locked burst has no single target slave");

endmodule

// ==== rtl/b_router.sv ====
`timescale 1ns/1ps

module b_router
  import axi_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      awvalid_s0,
  input  logic      awvalid_s1,
  input  logic      awvalid_s2,
  input  logic      awready_s0,
  input  logic      awready_s1,
  input  logic      awready_s2,
  output axi_id_t   bid_m1,
  output axi_resp_t bresp_m1,
  output logic      bvalid_m1,
  input  logic      bready_m1,
  input  axi_id_t   bid_s0,
  input  axi_resp_t bresp_s0,
  input  logic      bvalid_s0,
  output logic      bready_s0,
  input  axi_id_t   bid_s1,
  input  axi_resp_t bresp_s1,
  input  logic      bvalid_s1,
  output logic      bready_s1,
  input  axi_id_t   bid_s2,
  input  axi_resp_t bresp_s2,
  input  logic      bvalid_s2,
  output logic      bready_s2
);

  data_arb_lock_t b_sel;

  // Owner of the outstanding write
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      b_sel <= LOCK_NO;
    end else if (awvalid_s0 && awready_s0) begin
      b_sel <= LOCK_S0;
    end else if (awvalid_s1 && awready_s1) begin
      b_sel <= LOCK_S1;
    end else if (awvalid_s2 && awready_s2) begin
      b_sel <= LOCK_S2;
    end else if (bvalid_m1 && bready_m1) begin
      b_sel <= LOCK_NO;
    end
  end

  always_comb begin
    bid_m1    = '0;
    bresp_m1  = '0;
    bvalid_m1 = 1'b0;
    bready_s0 = 1'b0;
    bready_s1 = 1'b0;
    bready_s2 = 1'b0;
    case (b_sel)
      LOCK_S0: begin
        bid_m1    = bid_s0;
        bresp_m1  = bresp_s0;
        bvalid_m1 = bvalid_s0;
        bready_s0 = bready_m1;
      end
      LOCK_S1: begin
        bid_m1    = bid_s1;
        bresp_m1  = bresp_s1;
        bvalid_m1 = bvalid_s1;
        bready_s1 = bready_m1;
      end
      LOCK_S2: begin
        bid_m1    = bid_s2;
        bresp_m1  = bresp_s2;
        bvalid_m1 = bvalid_s2;
        bready_s2 = bready_m1;
      end
      default: ;
    endcase
  end

  // A response from any other slave would be lost
  a_b_owner: assert property (@(posedge clk) disable iff (!rstn)
    (bvalid_s0 |-> b_sel == LOCK_S0) and
    (bvalid_s1 |-> b_sel == LOCK_S1) and
    (bvalid_s2 |-> b_sel == LOCK_S2))
    else $error("b_router: bvalid from a slave that holds no write");

endmodule

// ==== rtl/sram_slave.sv ====
`timescale 1ns/1ps
`include "axi_params.svh"

module sram_slave
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  axi_id_t    awid,
  input  axi_addr_t  awaddr,
  input  axi_len_t   awlen,
  input  logic       awvalid,
  output logic       awready,
  input  axi_data_t  wdata,
  input  axi_strb_t  wstrb,
  input  logic       wlast,
  input  logic       wvalid,
  output logic       wready,
  output axi_id_t    bid,
  output axi_resp_t  bresp,
  output logic       bvalid,
  input  logic       bready,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  mem_index_t wb_adr,
  output axi_data_t  wb_dat,
  output logic       wb_ack
);

  localparam int MEM_WORDS = 1 << `MEM_WORDS_LOG2;

  slave_state_t state;
  slave_state_t state_next;
  axi_id_t      id_r;
  axi_len_t     len_r;
  axi_len_t     beat_cnt;
  mem_index_t   wr_idx;
  axi_data_t    mem [MEM_WORDS];
  logic         aw_hs;
  logic         w_hs;

  assign awready = (state == S_IDLE);
  assign wready  = (state == S_DATA);
  assign bvalid  = (state == S_RESP);
  assign bid     = id_r;
  assign bresp   = 2'b00;

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE:  if (aw_hs) state_next = S_DATA;
      S_DATA:  if (w_hs && wlast) state_next = S_RESP;
      S_RESP:  if (bready) state_next = S_IDLE;
      default: state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      beat_cnt <= '0;
    end else if (aw_hs) begin
      beat_cnt <= '0;
    end else if (w_hs) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // INCR burst, one word per beat
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_r   <= awid;
      len_r  <= awlen;
      wr_idx <= awaddr[`MEM_WORDS_LOG2+1:2];
    end else if (w_hs) begin
      wr_idx <= wr_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (w_hs) begin
      for (int b = 0; b < `AXI_STRB_BITS; b++) begin
        if (wstrb[b]) begin
          mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
    if (wb_cyc && wb_stb) begin
      wb_dat <= mem[wb_adr];
    end
  end

  // Single-cycle ack, dropped while the master releases stb
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_cyc && wb_stb && !wb_ack;
    end
  end

  a_wlast_beat: assert property (@(posedge clk) disable iff (!rstn)
    w_hs |-> (wlast == (beat_cnt == len_r)))
    else $error("sram_slave: wlast on beat %0d, burst has %0d beats", beat_cnt + 1, len_r + 1);

endmodule

// ==== rtl/axi_write_top.sv ====
`timescale 1ns/1ps

module axi_write_top
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  axi_id_t    awid_m1,
  input  axi_addr_t  awaddr_m1,
  input  axi_len_t   awlen_m1,
  input  logic       awvalid_m1,
  output logic       awready_m1,
  input  axi_data_t  wdata_m1,
  input  axi_strb_t  wstrb_m1,
  input  logic       wlast_m1,
  input  logic       wvalid_m1,
  output logic       wready_m1,
  output axi_id_t    bid_m1,
  output axi_resp_t  bresp_m1,
  output logic       bvalid_m1,
  input  logic       bready_m1,
  input  logic       wb_cyc_s0,
  input  logic       wb_stb_s0,
  input  mem_index_t wb_adr_s0,
  output axi_data_t  wb_dat_s0,
  output logic       wb_ack_s0,
  input  logic       wb_cyc_s1,
  input  logic       wb_stb_s1,
  input  mem_index_t wb_adr_s1,
  output axi_data_t  wb_dat_s1,
  output logic       wb_ack_s1,
  input  logic       wb_cyc_s2,
  input  logic       wb_stb_s2,
  input  mem_index_t wb_adr_s2,
  output axi_data_t  wb_dat_s2,
  output logic       wb_ack_s2
);

  logic      awvalid_s0, awvalid_s1, awvalid_s2;
  logic      awready_s0, awready_s1, awready_s2;
  axi_data_t wdata_s0, wdata_s1, wdata_s2;
  axi_strb_t wstrb_s0, wstrb_s1, wstrb_s2;
  logic      wlast_s0, wlast_s1, wlast_s2;
  logic      wvalid_s0, wvalid_s1, wvalid_s2;
  logic      wready_s0, wready_s1, wready_s2;
  axi_id_t   bid_s0, bid_s1, bid_s2;
  axi_resp_t bresp_s0, bresp_s1, bresp_s2;
  logic      bvalid_s0, bvalid_s1, bvalid_s2;
  logic      bready_s0, bready_s1, bready_s2;

  aw_router u_aw (
    .awaddr_m1(awaddr_m1), .awvalid_m1(awvalid_m1), .awready_m1(awready_m1),
    .awvalid_s0(awvalid_s0), .awvalid_s1(awvalid_s1), .awvalid_s2(awvalid_s2),
    .awready_s0(awready_s0), .awready_s1(awready_s1), .awready_s2(awready_s2)
  );

  w_router u_w (
    .clk(clk), .rstn(rstn),
    .wdata_m1(wdata_m1), .wstrb_m1(wstrb_m1), .wlast_m1(wlast_m1),
    .wvalid_m1(wvalid_m1), .wready_m1(wready_m1), .awvalid_m1(awvalid_m1),
    .wdata_s0(wdata_s0), .wstrb_s0(wstrb_s0), .wlast_s0(wlast_s0), .wvalid_s0(wvalid_s0),
    .wready_s0(wready_s0), .awvalid_s0(awvalid_s0), .awready_s0(awready_s0),
    .wdata_s1(wdata_s1), .wstrb_s1(wstrb_s1), .wlast_s1(wlast_s1), .wvalid_s1(wvalid_s1),
    .wready_s1(wready_s1), .awvalid_s1(awvalid_s1), .awready_s1(awready_s1),
    .wdata_s2(wdata_s2), .wstrb_s2(wstrb_s2), .wlast_s2(wlast_s2), .wvalid_s2(wvalid_s2),
    .wready_s2(wready_s2), .awvalid_s2(awvalid_s2), .awready_s2(awready_s2)
  );

  b_router u_b (
    .clk(clk), .rstn(rstn),
    .awvalid_s0(awvalid_s0), .awvalid_s1(awvalid_s1), .awvalid_s2(awvalid_s2),
    .awready_s0(awready_s0), .awready_s1(awready_s1), .awready_s2(awready_s2),
    .bid_m1(bid_m1), .bresp_m1(bresp_m1), .bvalid_m1(bvalid_m1), .bready_m1(bready_m1),
    .bid_s0(bid_s0), .bresp_s0(bresp_s0), .bvalid_s0(bvalid_s0), .bready_s0(bready_s0),
    .bid_s1(bid_s1), .bresp_s1(bresp_s1), .bvalid_s1(bvalid_s1), .bready_s1(bready_s1),
    .bid_s2(bid_s2), .bresp_s2(bresp_s2), .bvalid_s2(bvalid_s2), .bready_s2(bready_s2)
  );

  // AW payload is broadcast, only awvalid is routed
  sram_slave u_s0 (
    .clk(clk), .rstn(rstn),
    .awid(awid_m1), .awaddr(awaddr_m1), .awlen(awlen_m1),
    .awvalid(awvalid_s0), .awready(awready_s0),
    .wdata(wdata_s0), .wstrb(wstrb_s0), .wlast(wlast_s0),
    .wvalid(wvalid_s0), .wready(wready_s0),
    .bid(bid_s0), .bresp(bresp_s0), .bvalid(bvalid_s0), .bready(bready_s0),
    .wb_cyc(wb_cyc_s0), .wb_stb(wb_stb_s0), .wb_adr(wb_adr_s0),
    .wb_dat(wb_dat_s0), .wb_ack(wb_ack_s0)
  );

  sram_slave u_s1 (
    .clk(clk), .rstn(rstn),
    .awid(awid_m1), .awaddr(awaddr_m1), .awlen(awlen_m1),
    .awvalid(awvalid_s1), .awready(awready_s1),
    .wdata(wdata_s1), .wstrb(wstrb_s1), .wlast(wlast_s1),
    .wvalid(wvalid_s1), .wready(wready_s1),
    .bid(bid_s1), .bresp(bresp_s1), .bvalid(bvalid_s1), .bready(bready_s1),
    .wb_cyc(wb_cyc_s1), .wb_stb(wb_stb_s1), .wb_adr(wb_adr_s1),
    .wb_dat(wb_dat_s1), .wb_ack(wb_ack_s1)
  );

  sram_slave u_s2 (
    .clk(clk), .rstn(rstn),
    .awid(awid_m1), .awaddr(awaddr_m1), .awlen(awlen_m1),
    .awvalid(awvalid_s2), .awready(awready_s2),
    .wdata(wdata_s2), .wstrb(wstrb_s2), .wlast(wlast_s2),
    .wvalid(wvalid_s2), .wready(wready_s2),
    .bid(bid_s2), .bresp(bresp_s2), .bvalid(bvalid_s2), .bready(bready_s2),
    .wb_cyc(wb_cyc_s2), .wb_stb(wb_stb_s2), .wb_adr(wb_adr_s2),
    .wb_dat(wb_dat_s2), .wb_ack(wb_ack_s2)
  );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

// ==== testbench/tb_axi_write.sv ====
`timescale 1ns/1ps
`include "axi_params.svh"

module tb_axi_write
  import axi_pkg::*;
();

  localparam int MEM_WORDS      = 1 << `MEM_WORDS_LOG2;
  localparam int TIMEOUT_CYCLES = 100;
  localparam int SETTLE_NS      = 2;

  logic       clk;
  logic       rstn;
  axi_id_t    awid_m1;
  axi_addr_t  awaddr_m1;
  axi_len_t   awlen_m1;
  logic       awvalid_m1;
  logic       awready_m1;
  axi_data_t  wdata_m1;
  axi_strb_t  wstrb_m1;
  logic       wlast_m1;
  logic       wvalid_m1;
  logic       wready_m1;
  axi_id_t    bid_m1;
  axi_resp_t  bresp_m1;
  logic       bvalid_m1;
  logic       bready_m1;
  logic [2:0] wb_cyc;
  logic [2:0] wb_stb;
  mem_index_t wb_adr;
  wire  [2:0] wb_ack;
  axi_data_t  wb_dat_s0;
  axi_data_t  wb_dat_s1;
  axi_data_t  wb_dat_s2;

  axi_data_t   shadow [3][MEM_WORDS];
  axi_data_t   beat_data [16];
  axi_strb_t   beat_strb [16];
  logic [31:0] lcg_state = 32'h55b4_b353;
  int          checks = 0;
  int          errors = 0;

  tb_clock #(.PERIOD_NS(40)) u_clk (.clk(clk));

  axi_write_top DUT (
    .clk(clk), .rstn(rstn),
    .awid_m1(awid_m1), .awaddr_m1(awaddr_m1), .awlen_m1(awlen_m1),
    .awvalid_m1(awvalid_m1), .awready_m1(awready_m1),
    .wdata_m1(wdata_m1), .wstrb_m1(wstrb_m1), .wlast_m1(wlast_m1),
    .wvalid_m1(wvalid_m1), .wready_m1(wready_m1),
    .bid_m1(bid_m1), .bresp_m1(bresp_m1), .bvalid_m1(bvalid_m1), .bready_m1(bready_m1),
    .wb_cyc_s0(wb_cyc[0]), .wb_stb_s0(wb_stb[0]), .wb_adr_s0(wb_adr),
    .wb_dat_s0(wb_dat_s0), .wb_ack_s0(wb_ack[0]),
    .wb_cyc_s1(wb_cyc[1]), .wb_stb_s1(wb_stb[1]), .wb_adr_s1(wb_adr),
    .wb_dat_s1(wb_dat_s1), .wb_ack_s1(wb_ack[1]),
    .wb_cyc_s2(wb_cyc[2]), .wb_stb_s2(wb_stb[2]), .wb_adr_s2(wb_adr),
    .wb_dat_s2(wb_dat_s2), .wb_ack_s2(wb_ack[2])
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'((lcg_next() >> 8) % n);
  endfunction

  // Region in bits 17:16, word index in bits 9:2
  function automatic axi_addr_t region_addr(input int s, input mem_index_t idx);
    axi_addr_t addr;
    addr = '0;
    addr[`REGION_MSB:`REGION_LSB] = s[1:0];
    addr[`MEM_WORDS_LOG2+1:2] = idx;
    return addr;
  endfunction

  function automatic axi_data_t fill_pattern(input int s, input mem_index_t idx);
    axi_addr_t addr;
    addr = region_addr(s, idx);
    return 32'h3c5a_0000 ^ (addr << 12) ^ addr;
  endfunction

  // Expected word: only strobed bytes take the new data
  function automatic axi_data_t merge_bytes(input axi_data_t old_word,
                                            input axi_data_t new_word,
                                            input axi_strb_t strb);
    axi_data_t result;
    result = old_word;
    for (int b = 0; b < `AXI_STRB_BITS; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout: %s did not arrive within %0d cycles", what, TIMEOUT_CYCLES);
  endtask

  task automatic test_done(input string name, input int err_mark);
    $display("test %-14s : %s", name, (errors == err_mark) ? "pass" : "FAIL");
  endtask

  task automatic drive_beat(input int beat, input int len);
    wdata_m1  = beat_data[beat];
    wstrb_m1  = beat_strb[beat];
    wlast_m1  = (beat == len);
    wvalid_m1 = 1'b1;
  endtask

  task automatic load_beats(input int len, input bit full_strb);
    for (int i = 0; i <= len; i++) begin
      beat_data[i] = lcg_next();
      beat_strb[i] = full_strb ? 4'hf : axi_strb_t'(lcg_next());
    end
  endtask

  task automatic axi_write(input int s, input mem_index_t idx, input int len, input axi_id_t id,
                           input bit fast, input int w_delay, input int b_delay);
    int   n;
    int   beat;
    logic bv_pre;
    @(negedge clk);
    awid_m1    = id;
    awaddr_m1  = region_addr(s, idx);
    awlen_m1   = axi_len_t'(len);
    awvalid_m1 = 1'b1;
    if (fast) begin
      drive_beat(0, len);
    end
    n = 0;
    #(SETTLE_NS);
    while (!awready_m1 && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      #(SETTLE_NS);
      n++;
    end
    if (!awready_m1) begin
      report_timeout($sformatf("awready_m1 for slave %0d", s));
      awvalid_m1 = 1'b0;
      wvalid_m1  = 1'b0;
      return;
    end
    @(negedge clk);
    awvalid_m1 = 1'b0;
    if (!fast) begin
      repeat (w_delay) @(negedge clk);
      drive_beat(0, len);
    end
    beat   = 0;
    n      = 0;
    bv_pre = 1'b0;
    while (beat <= len && n < TIMEOUT_CYCLES) begin
      #(SETTLE_NS);
      if (wready_m1) begin
        shadow[s][mem_index_t'(idx + beat)] =
          merge_bytes(shadow[s][mem_index_t'(idx + beat)], beat_data[beat], beat_strb[beat]);
        bv_pre = bvalid_m1;
        beat++;
        n = 0;
      end else begin
        n++;
      end
      @(negedge clk);
      if (beat <= len) begin
        drive_beat(beat, len);
      end else begin
        wvalid_m1 = 1'b0;
      end
    end
    if (beat <= len) begin
      report_timeout($sformatf("wready_m1 for beat %0d", beat));
      wvalid_m1 = 1'b0;
      return;
    end
    // Response follows the last beat by exactly one cycle
    check("bvalid_m1 on last beat", bv_pre, 1'b0);
    check("bvalid_m1 after last beat", bvalid_m1, 1'b1);
    n = 0;
    while (!bvalid_m1 && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!bvalid_m1) begin
      report_timeout("bvalid_m1");
      return;
    end
    check("bid_m1", bid_m1, id);
    check("bresp_m1", bresp_m1, 2'b00);
    repeat (b_delay) begin
      @(negedge clk);
      check("bvalid_m1 held", bvalid_m1, 1'b1);
      check("bid_m1 held", bid_m1, id);
    end
    bready_m1 = 1'b1;
    @(negedge clk);
    bready_m1 = 1'b0;
    check("bvalid_m1 after B handshake", bvalid_m1, 1'b0);
  endtask

  task automatic read_word(input int s, input mem_index_t idx, output axi_data_t data);
    int n;
    @(negedge clk);
    wb_adr    = idx;
    wb_cyc[s] = 1'b1;
    wb_stb[s] = 1'b1;
    n = 0;
    @(negedge clk);
    while (!wb_ack[s] && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!wb_ack[s]) begin
      report_timeout($sformatf("Wishbone ack from slave %0d", s));
    end
    data = (s == 0) ? wb_dat_s0 : (s == 1) ? wb_dat_s1 : wb_dat_s2;
    wb_cyc[s] = 1'b0;
    wb_stb[s] = 1'b0;
  endtask

  task automatic verify_words(input int s, input mem_index_t idx, input int count);
    axi_data_t  got;
    mem_index_t a;
    for (int i = 0; i < count; i++) begin
      a = mem_index_t'(idx + i);
      read_word(s, a, got);
      check($sformatf("wb_dat_s%0d[%0d]", s, a), got, shadow[s][a]);
    end
  endtask

  task automatic random_write(input bit full_strb, input bit fast,
                              input int w_delay, input int b_delay);
    int         s;
    int         len;
    mem_index_t idx;
    s   = rand_below(3);
    len = rand_below(16);
    idx = mem_index_t'(rand_below(MEM_WORDS - len));
    load_beats(len, full_strb);
    axi_write(s, idx, len, axi_id_t'(rand_below(16)), fast, w_delay, b_delay);
    verify_words(s, idx, len + 1);
  endtask

  initial begin
    int         err_mark;
    mem_index_t idx;
    bit         fast;
    rstn       = 1'b0;
    awid_m1    = '0;
    awaddr_m1  = '0;
    awlen_m1   = '0;
    awvalid_m1 = 1'b0;
    wdata_m1   = '0;
    wstrb_m1   = '0;
    wlast_m1   = 1'b0;
    wvalid_m1  = 1'b0;
    bready_m1  = 1'b0;
    wb_cyc     = '0;
    wb_stb     = '0;
    wb_adr     = '0;

    err_mark = errors;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check("awready_m1", awready_m1, 1'b0);
    check("wready_m1", wready_m1, 1'b0);
    check("bvalid_m1", bvalid_m1, 1'b0);
    check("wb_ack", wb_ack, 3'b000);
    test_done("reset", err_mark);

    err_mark = errors;
    for (int s = 0; s < 3; s++) begin
      for (int blk = 0; blk < MEM_WORDS / 16; blk++) begin
        for (int i = 0; i < 16; i++) begin
          beat_data[i] = fill_pattern(s, mem_index_t'(blk * 16 + i));
          beat_strb[i] = 4'hf;
        end
        axi_write(s, mem_index_t'(blk * 16), 15, axi_id_t'(blk), 1'b0, 0, 0);
      end
    end
    test_done("memory fill", err_mark);

    err_mark = errors;
    for (int s = 0; s < 3; s++) begin
      idx = mem_index_t'(rand_below(MEM_WORDS));
      load_beats(0, 1'b1);
      axi_write(s, idx, 0, axi_id_t'(rand_below(16)), 1'b0, 0, 0);
      // Same index in the other regions must keep its old word
      for (int r = 0; r < 3; r++) begin
        verify_words(r, idx, 1);
      end
    end
    test_done("region routing", err_mark);

    err_mark = errors;
    repeat (6) random_write(1'b1, 1'b0, 0, 0);
    test_done("bursts", err_mark);

    err_mark = errors;
    repeat (6) random_write(1'b0, 1'b0, 0, 0);
    test_done("strobes", err_mark);

    err_mark = errors;
    for (int i = 0; i < 8; i++) begin
      fast = (i % 2 == 0);
      random_write(1'b0, fast, fast ? 0 : 1 + rand_below(6), 0);
    end
    test_done("w paths", err_mark);

    err_mark = errors;
    for (int i = 0; i < 4; i++) begin
      fast = (i % 2 == 1);
      random_write(1'b1, fast, fast ? 0 : rand_below(4), 1 + rand_below(8));
    end
    test_done("b backpressure", err_mark);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
rtl/axi_pkg.sv
rtl/aw_router.sv
rtl/w_router.sv
rtl/b_router.sv
rtl/sram_slave.sv
rtl/axi_write_top.sv
testbench/tb_clock.sv
testbench/tb_axi_write.sv
